// ==== verilog/phys_pkg.sv ====
`default_nettype none

package phys_pkg;

    localparam int NUM_ARCH_REGS = 32;
    localparam int NUM_PHYS_REGS = 64;
    localparam int FREE_DEPTH    = 32;  // physical regs not held by any arch reg

    localparam int ARCH_IDX_W = $clog2(NUM_ARCH_REGS);
    localparam int PHYS_IDX_W = $clog2(NUM_PHYS_REGS);

    typedef logic [ARCH_IDX_W-1:0] arch_reg_t;
    typedef logic [PHYS_IDX_W-1:0] phys_reg_t;

    // one entry per architectural register, entry i at bits [6*i +: 6]
    typedef phys_reg_t [NUM_ARCH_REGS-1:0] phys_map_t;

endpackage

`default_nettype wire

// ==== verilog/rename_msg_pkg.sv ====
`default_nettype none

package rename_msg_pkg;

    typedef struct packed {
        phys_pkg::arch_reg_t rd;
        phys_pkg::arch_reg_t rs1;
        phys_pkg::arch_reg_t rs2;
        logic                has_rd;  // instruction writes rd
    } rename_req_t;

    typedef struct packed {
        phys_pkg::phys_reg_t prd;
        phys_pkg::phys_reg_t prs1;
        phys_pkg::phys_reg_t prs2;
        phys_pkg::phys_reg_t old_prd;  // previous mapping of rd, freed at retire
    } rename_resp_t;

    typedef struct packed {
        phys_pkg::arch_reg_t rd;
        phys_pkg::phys_reg_t prd;
    } retire_req_t;

    typedef struct packed {
        phys_pkg::phys_reg_t freed;  // goes back to the free list
    } retire_resp_t;

endpackage

`default_nettype wire

// ==== verilog/free_list.sv ====
`default_nettype none

module free_list #(
    parameter int DEPTH = phys_pkg::FREE_DEPTH
) (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                enq,
    input  wire phys_pkg::phys_reg_t enq_reg,
    input  wire logic                deq,
    output phys_pkg::phys_reg_t      head_reg,
    output logic                     empty,
    input  wire logic                rebuild,
    input  wire phys_pkg::phys_map_t committed
);

    localparam int ADDR_W = $clog2(DEPTH);

    typedef logic [ADDR_W:0] ptr_t;  // msb is the wrap bit

    phys_pkg::phys_reg_t mem [DEPTH];
    phys_pkg::phys_reg_t rebuilt [DEPTH];

    ptr_t head_ptr;
    ptr_t tail_ptr;
    ptr_t fill_cnt;  // number of entries packed by a rebuild

    logic [phys_pkg::NUM_PHYS_REGS-1:0] used;

    assign empty    = (head_ptr == tail_ptr);  // same index and same wrap
    assign head_reg = mem[head_ptr[ADDR_W-1:0]];

    // mark every physical reg the committed map points at
    always_comb begin
        used = '0;
        for (int a = 0; a < phys_pkg::NUM_ARCH_REGS; a++) begin
            used[committed[a]] = 1'b1;
        end
    end

    // pack the unused regs in ascending order from entry 0
    always_comb begin
        fill_cnt = '0;
        for (int i = 0; i < DEPTH; i++) begin
            rebuilt[i] = '0;
        end
        for (int p = 0; p < phys_pkg::NUM_PHYS_REGS; p++) begin
            if (!used[p] && (fill_cnt < ptr_t'(DEPTH))) begin
                rebuilt[fill_cnt[ADDR_W-1:0]] = phys_pkg::phys_reg_t'(p);
                fill_cnt = fill_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= phys_pkg::phys_reg_t'(phys_pkg::NUM_ARCH_REGS + i);
            end
            head_ptr <= '0;
            tail_ptr <= ptr_t'(DEPTH);  // full, wrap bit set
        end else if (rebuild) begin  // flush wins over enq and deq
            mem      <= rebuilt;
            head_ptr <= '0;
            tail_ptr <= fill_cnt;
        end else begin
            if (enq) begin
                mem[tail_ptr[ADDR_W-1:0]] <= enq_reg;
                tail_ptr <= tail_ptr + 1'b1;
            end
            if (deq && !empty) begin  // dequeue on empty is dropped
                head_ptr <= head_ptr + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/rename_map.sv ====
`default_nettype none

module rename_map (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire phys_pkg::arch_reg_t rs1,
    input  wire phys_pkg::arch_reg_t rs2,
    input  wire phys_pkg::arch_reg_t rd,
    output phys_pkg::phys_reg_t      prs1,
    output phys_pkg::phys_reg_t      prs2,
    output phys_pkg::phys_reg_t      old_prd,
    input  wire logic                write,
    input  wire phys_pkg::phys_reg_t new_prd,
    input  wire logic                restore,
    input  wire phys_pkg::phys_map_t committed
);

    phys_pkg::phys_map_t spec_map;  // speculative arch -> phys table

    // asynchronous read ports
    assign prs1    = spec_map[rs1];
    assign prs2    = spec_map[rs2];
    assign old_prd = spec_map[rd];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < phys_pkg::NUM_ARCH_REGS; i++) begin
                spec_map[i] <= phys_pkg::phys_reg_t'(i);  // identity map
            end
        end else if (restore) begin
            spec_map <= committed;  // roll back to the committed state
        end else if (write) begin
            spec_map[rd] <= new_prd;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/retire_map.sv ====
`default_nettype none

module retire_map (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                write,
    input  wire phys_pkg::arch_reg_t rd,
    input  wire phys_pkg::phys_reg_t prd,
    output phys_pkg::phys_reg_t      freed,
    output phys_pkg::phys_map_t      committed
);

    phys_pkg::phys_map_t commit_map;

    assign freed     = commit_map[rd];  // displaced by this retire
    assign committed = commit_map;      // whole table for flush recovery

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < phys_pkg::NUM_ARCH_REGS; i++) begin
                commit_map[i] <= phys_pkg::phys_reg_t'(i);
            end
        end else if (write) begin
            commit_map[rd] <= prd;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/hs_endpoint.sv ====
`default_nettype none

module hs_endpoint #(
    parameter type payload_t = logic,
    parameter type resp_t    = logic
) (
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire logic     req,
    input  wire payload_t data,
    output logic          ack,
    output resp_t         resp,
    input  wire logic     core_ready,
    output logic          fire,
    output payload_t      payload,
    input  wire resp_t    core_resp
);

    typedef enum logic [1:0] {
        IDLE,
        BUSY,   // core works on the payload this cycle
        ACKED   // response held until req drops
    } hs_state_t;

    hs_state_t state;
    logic      accept;

    assign accept = (state == IDLE) && req && core_ready;
    assign fire   = (state == BUSY);
    assign ack    = (state == ACKED);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:    if (accept) state <= BUSY;
                BUSY:    state <= ACKED;
                ACKED:   if (!req) state <= IDLE;  // return to zero
                default: state <= IDLE;
            endcase
        end
    end

    // payload and response registers
    always_ff @(posedge clk) begin
        if (accept) begin
            payload <= data;
        end
        if (fire) begin
            resp <= core_resp;  // stays stable while ack is high
        end
    end

endmodule

`default_nettype wire

// ==== verilog/rename_unit.sv ====
`default_nettype none

module rename_unit (
    input  wire logic                         clk,
    input  wire logic                         rst,
    input  wire logic                         ren_req,
    input  wire rename_msg_pkg::rename_req_t  ren_data,
    output logic                              ren_ack,
    output rename_msg_pkg::rename_resp_t      ren_resp,
    input  wire logic                         ret_req,
    input  wire rename_msg_pkg::retire_req_t  ret_data,
    output logic                              ret_ack,
    output rename_msg_pkg::retire_resp_t      ret_resp,
    input  wire logic                         flush,
    output logic                              free_empty
);

    logic                         ren_fire;
    logic                         ret_fire;
    rename_msg_pkg::rename_req_t  ren_payload;
    rename_msg_pkg::retire_req_t  ret_payload;
    rename_msg_pkg::rename_resp_t ren_core_resp;
    rename_msg_pkg::retire_resp_t ret_core_resp;
    phys_pkg::phys_reg_t          free_head;
    phys_pkg::phys_reg_t          map_prs1;
    phys_pkg::phys_reg_t          map_prs2;
    phys_pkg::phys_reg_t          map_old_prd;
    phys_pkg::phys_map_t          committed_map;

    assign ren_core_resp = '{
        prd:     ren_payload.has_rd ? free_head : map_old_prd,
        prs1:    map_prs1,
        prs2:    map_prs2,
        old_prd: map_old_prd
    };

    hs_endpoint #(
        .payload_t(rename_msg_pkg::rename_req_t),
        .resp_t   (rename_msg_pkg::rename_resp_t)
    ) u_ren_ep (
        .clk       (clk),
        .rst       (rst),
        .req       (ren_req),
        .data      (ren_data),
        .ack       (ren_ack),
        .resp      (ren_resp),
        .core_ready(!(ren_data.has_rd && free_empty)),  // stall only when allocation is impossible
        .fire      (ren_fire),
        .payload   (ren_payload),
        .core_resp (ren_core_resp)
    );

    hs_endpoint #(
        .payload_t(rename_msg_pkg::retire_req_t),
        .resp_t   (rename_msg_pkg::retire_resp_t)
    ) u_ret_ep (
        .clk       (clk),
        .rst       (rst),
        .req       (ret_req),
        .data      (ret_data),
        .ack       (ret_ack),
        .resp      (ret_resp),
        .core_ready(1'b1),
        .fire      (ret_fire),
        .payload   (ret_payload),
        .core_resp (ret_core_resp)
    );

    free_list u_free_list (
        .clk      (clk),
        .rst      (rst),
        .enq      (ret_fire),
        .enq_reg  (ret_core_resp.freed),
        .deq      (ren_fire && ren_payload.has_rd),
        .head_reg (free_head),
        .empty    (free_empty),
        .rebuild  (flush),
        .committed(committed_map)
    );

    rename_map u_rename_map (
        .clk      (clk),
        .rst      (rst),
        .rs1      (ren_payload.rs1),
        .rs2      (ren_payload.rs2),
        .rd       (ren_payload.rd),
        .prs1     (map_prs1),
        .prs2     (map_prs2),
        .old_prd  (map_old_prd),
        .write    (ren_fire && ren_payload.has_rd),
        .new_prd  (free_head),
        .restore  (flush),
        .committed(committed_map)
    );

    retire_map u_retire_map (
        .clk      (clk),
        .rst      (rst),
        .write    (ret_fire),
        .rd       (ret_payload.rd),
        .prd      (ret_payload.prd),
        .freed    (ret_core_resp.freed),
        .committed(committed_map)
    );

endmodule

`default_nettype wire

// ==== testbench/rename_assertions.sv ====
`default_nettype none

module rename_assertions (
    input wire logic                        clk,
    input wire logic                        rst,
    input wire logic                        ren_req,
    input wire logic                        ren_ack,
    input wire rename_msg_pkg::rename_req_t ren_data,
    input wire logic                        ret_req,
    input wire logic                        ret_ack,
    input wire rename_msg_pkg::retire_req_t ret_data,
    input wire logic                        ren_fire,
    input wire rename_msg_pkg::rename_req_t ren_payload,
    input wire logic                        free_empty,
    input wire logic                        flush
);

    // req was high at the edge where ack went up
    ack_needs_req: assert property (@(posedge clk) disable iff (rst)
        (!$rose(ren_ack) || $past(ren_req)) && (!$rose(ret_ack) || $past(ret_req)))
        else $error("ack rose without req");

    ren_req_held: assert property (@(posedge clk) disable iff (rst)
        ren_req && !ren_ack |=> ren_req || ren_ack)
        else $error("rename req dropped before ack");

    ret_req_held: assert property (@(posedge clk) disable iff (rst)
        ret_req && !ret_ack |=> ret_req || ret_ack)
        else $error("retire req dropped before ack");

    data_stable: assert property (@(posedge clk) disable iff (rst)
        (!(ren_req && $past(ren_req)) || $stable(ren_data))
        && (!(ret_req && $past(ret_req)) || $stable(ret_data)))
        else $error("request data changed while req was high");

    // a dequeue on an empty free list would hand out a stale reg
    no_deq_empty: assert property (@(posedge clk) disable iff (rst)
        !(ren_fire && ren_payload.has_rd && free_empty))
        else $error("free list dequeued while empty");

    flush_idle: assert property (@(posedge clk) disable iff (rst)
        flush |-> !(ren_req || ren_ack || ret_req || ret_ack))
        else $error("flush while a channel was busy");

endmodule

bind rename_unit rename_assertions u_rename_assertions (.*);

`default_nettype wire

// ==== testbench/tb_rename_unit.sv ====
`default_nettype none

module tb_rename_unit;

    logic                         clk = 1'b0;
    logic                         rst;
    logic                         ren_req;
    rename_msg_pkg::rename_req_t  ren_data;
    logic                         ren_ack;
    rename_msg_pkg::rename_resp_t ren_resp;
    logic                         ret_req;
    rename_msg_pkg::retire_req_t  ret_data;
    logic                         ret_ack;
    rename_msg_pkg::retire_resp_t ret_resp;
    logic                         flush;
    logic                         free_empty;

    logic [15:0] lfsr = 16'd67;
    int          errors = 0;
    int          checks = 0;
    bit          timed_out = 1'b0;

    phys_pkg::phys_reg_t         ren_tbl [phys_pkg::NUM_ARCH_REGS];  // model speculative map
    phys_pkg::phys_reg_t         ret_tbl [phys_pkg::NUM_ARCH_REGS];  // model committed map
    phys_pkg::phys_reg_t         free_q [$];
    rename_msg_pkg::retire_req_t inflight [$];  // renames with rd in age order

    rename_unit UUT (.*);

    always #20 clk = ~clk;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic int take_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = (v << 1) | int'(lfsr[0]);
        end
        return v;
    endfunction

    function automatic rename_msg_pkg::rename_req_t random_rename(input bit force_rd);
        rename_msg_pkg::rename_req_t r;
        r.rd     = phys_pkg::arch_reg_t'(take_bits(5));
        r.rs1    = phys_pkg::arch_reg_t'(take_bits(5));
        r.rs2    = phys_pkg::arch_reg_t'(take_bits(5));
        r.has_rd = force_rd || (take_bits(1) != 0);
        return r;
    endfunction

    task automatic check_val(input string what, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("FAILED at %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic wait_ack(input bit on_ren, input logic level, input string what);
        int n;
        n = 0;
        while (((on_ren ? ren_ack : ret_ack) !== level) && n < 50) begin
            @(posedge clk);
            #1;
            n++;
        end
        if ((on_ren ? ren_ack : ret_ack) !== level) begin
            timed_out = 1'b1;
            $display("timeout at %0t while waiting for %s", $time, what);
        end
    endtask

    // req is already high with ren_data stable
    task automatic finish_rename();
        phys_pkg::phys_reg_t         exp_prd;
        rename_msg_pkg::retire_req_t entry;
        wait_ack(1'b1, 1'b1, "rename ack to rise");
        if (timed_out) return;
        exp_prd = ren_tbl[ren_data.rd];  // no destination keeps the old mapping
        if (ren_data.has_rd && free_q.size() > 0) begin
            exp_prd   = free_q.pop_front();
            entry.rd  = ren_data.rd;
            entry.prd = exp_prd;
            inflight.push_back(entry);
        end
        check_val("prs1", ren_resp.prs1, ren_tbl[ren_data.rs1]);
        check_val("prs2", ren_resp.prs2, ren_tbl[ren_data.rs2]);
        check_val("old_prd", ren_resp.old_prd, ren_tbl[ren_data.rd]);
        check_val("prd", ren_resp.prd, exp_prd);
        ren_tbl[ren_data.rd] = exp_prd;
        ren_req = 1'b0;
        wait_ack(1'b1, 1'b0, "rename ack to fall");
    endtask

    task automatic retire_oldest();
        rename_msg_pkg::retire_req_t r;
        r        = inflight.pop_front();
        ret_data = r;
        ret_req  = 1'b1;
        wait_ack(1'b0, 1'b1, "retire ack to rise");
        if (timed_out) return;
        check_val("freed", ret_resp.freed, ret_tbl[r.rd]);
        free_q.push_back(ret_tbl[r.rd]);  // displaced reg is allocated again later
        ret_tbl[r.rd] = r.prd;
        ret_req = 1'b0;
        wait_ack(1'b0, 1'b0, "retire ack to fall");
    endtask

    task automatic pulse_flush();
        logic [phys_pkg::NUM_PHYS_REGS-1:0] used;
        used  = '0;
        flush = 1'b1;
        @(posedge clk);
        #1;
        flush = 1'b0;
        inflight.delete();
        free_q.delete();
        for (int a = 0; a < phys_pkg::NUM_ARCH_REGS; a++) begin
            ren_tbl[a]       = ret_tbl[a];
            used[ret_tbl[a]] = 1'b1;
        end
        for (int p = 0; p < phys_pkg::NUM_PHYS_REGS; p++) begin
            if (!used[p]) begin
                free_q.push_back(phys_pkg::phys_reg_t'(p));  // ascending refill
            end
        end
    endtask

    initial begin
        int sel;
        rst      = 1'b1;
        ren_req  = 1'b0;
        ren_data = '0;
        ret_req  = 1'b0;
        ret_data = '0;
        flush    = 1'b0;
        for (int a = 0; a < phys_pkg::NUM_ARCH_REGS; a++) begin
            ren_tbl[a] = phys_pkg::phys_reg_t'(a);
            ret_tbl[a] = phys_pkg::phys_reg_t'(a);
        end
        for (int p = phys_pkg::NUM_ARCH_REGS; p < phys_pkg::NUM_PHYS_REGS; p++) begin
            free_q.push_back(phys_pkg::phys_reg_t'(p));
        end
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        check_val("free_empty after reset", free_empty, 0);

        // drain the free list from the identity map without retires
        for (int i = 0; i < phys_pkg::FREE_DEPTH && !timed_out; i++) begin
            ren_data = random_rename(1'b1);
            ren_req  = 1'b1;
            finish_rename();
        end
        if (!timed_out) begin
            check_val("free_empty when drained", free_empty, 1);
            ren_data = random_rename(1'b1);
            ren_req  = 1'b1;
            for (int n = 0; n < 12; n++) begin
                @(posedge clk);
                #1;
                check_val("ren_ack while stalled", ren_ack, 0);
            end
            retire_oldest();  // frees exactly one reg for the stalled rename
            finish_rename();
        end

        for (int step = 0; step < 600 && !timed_out; step++) begin
            sel = take_bits(4);
            if (sel == 15) begin
                pulse_flush();
            end else if ((sel >= 8 && inflight.size() > 0) || free_q.size() == 0) begin
                retire_oldest();
            end else begin
                ren_data = random_rename(1'b0);
                ren_req  = 1'b1;
                finish_rename();
            end
        end

        $display("checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timed_out);
        if (errors == 0 && !timed_out) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
verilog/phys_pkg.sv
verilog/rename_msg_pkg.sv
verilog/free_list.sv
verilog/rename_map.sv
verilog/retire_map.sv
verilog/hs_endpoint.sv
verilog/rename_unit.sv
testbench/rename_assertions.sv
testbench/tb_rename_unit.sv

// ==== run_sim.sh ====
#!/bin/bash
# build the rename testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal -f flist.f --top-module tb_rename_unit \
    -o sim_rename || exit 1
out=$(./obj_dir/sim_rename)
echo "$out"
echo "$out" | grep -q "Simulation PASSED" && exit 0 || exit 1
